// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/data_mem_model.sv
// Word-addressed main memory for the cache testbench.
// Stalls each request with mem_wait for a random 0 to 3 cycles, then completes it.
module data_mem_model (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::mem_req_t mem,
    output logic                 mem_wait,
    output dcache_pkg::word_t    mem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int DEPTH = 256;

    word_t      words [DEPTH];
    logic [7:0] widx;
    logic       active;
    logic [1:0] wait_left;   // stall cycles still owed to the current request

    // preload value, built from every bit of the word index
    function automatic word_t fill_word(input logic [7:0] a);
        return {16'hc0de, a, ~a};
    endfunction

    assign widx      = mem.addr[9:2];
    assign active    = mem.ren || mem.wen;
    assign mem_wait  = active && (wait_left != 2'd0);
    assign mem_rdata = words[widx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= fill_word(8'(i));
            end
            wait_left <= 2'($urandom_range(0, 3));
        end else if (active) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                if (mem.wen) begin
                    words[widx] <= mem.wdata;   // write completes here
                end
                wait_left <= 2'($urandom_range(0, 3));   // stall for the next request
            end
        end
    end

endmodule

// File: bench/dcache_tb.sv
// Testbench for the data cache: CPU stimulus, shadow memory and result checks.
// Simulation top; main memory is data_mem_model.
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int WORDS      = 256;
    localparam int WAIT_LIMIT = 200;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu;
    logic     halt;
    logic     hit;
    word_t    rdata;
    logic     flushed;
    mem_req_t mem;
    logic     mem_wait;
    word_t    mem_rdata;

    word_t shadow [WORDS];   // memory contents as the CPU should see them
    word_t exp_q [$];
    word_t act_q [$];
    string name_q [$];

    dcache dcache_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu       (cpu),
        .halt      (halt),
        .hit       (hit),
        .rdata     (rdata),
        .flushed   (flushed),
        .mem       (mem),
        .mem_wait  (mem_wait),
        .mem_rdata (mem_rdata)
    );

    data_mem_model mem_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem       (mem),
        .mem_wait  (mem_wait),
        .mem_rdata (mem_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // expected read data for a byte address
    function automatic word_t expected_word(input word_t addr);
        return shadow[addr[9:2]];
    endfunction

    function automatic word_t block_addr(input int tag, input int set, input int off);
        return word_t'((tag << 6) | (set << 3) | (off << 2));
    endfunction

    // hold one request until hit, sampling mid cycle after the falling edge
    task automatic run_access(input logic wr, input word_t addr, input word_t data,
                              output word_t got, output int waits);
        int cycles;
        @(negedge CLK);
        cpu.ren   = !wr;
        cpu.wen   = wr;
        cpu.addr  = dcache_addr_t'(addr);
        cpu.wdata = data;
        cycles    = 0;
        #5;
        while (!hit) begin
            if (cycles == WAIT_LIMIT) begin
                stop_run($sformatf("no hit for address %h after %0d cycles", addr, cycles));
            end
            @(negedge CLK);
            #5;
            cycles++;
        end
        got   = rdata;
        waits = cycles;
    endtask

    task automatic read_word(input string name, input word_t addr);
        word_t got;
        int    waits;
        run_access(1'b0, addr, '0, got, waits);
        name_q.push_back(name);
        exp_q.push_back(expected_word(addr));
        act_q.push_back(got);
    endtask

    // read that must already be cached
    task automatic expect_hit(input string name, input word_t addr);
        word_t got;
        int    waits;
        run_access(1'b0, addr, '0, got, waits);
        name_q.push_back(name);
        exp_q.push_back(expected_word(addr));
        act_q.push_back(got);
        compare_word({name, " latency"}, '0, word_t'(waits));
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        word_t got;
        int    waits;
        run_access(1'b1, addr, data, got, waits);
        shadow[addr[9:2]] = data;
    endtask

    task automatic wait_flushed();
        int cycles;
        cycles = 0;
        #5;
        while (!flushed) begin
            if (cycles == WAIT_LIMIT) begin
                stop_run("flushed did not rise after halt");
            end
            @(negedge CLK);
            #5;
            cycles++;
        end
    endtask

    // read results are compared one cycle after they are captured
    initial begin
        forever begin
            @(negedge CLK);
            while (act_q.size() > 0) begin
                compare_word(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        word_t b_addr;
        word_t r_addr;
        void'($urandom(61034));
        nRST = 1'b0;
        cpu  = '0;
        halt = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = mem_i.words[i];   // preload pattern of the model
        end

        // read miss, then hits on the same block
        read_word("read miss", block_addr(0, 0, 0));
        expect_hit("read hit", block_addr(0, 0, 0));
        read_word("read miss upper", block_addr(1, 1, 1));
        expect_hit("read hit lower", block_addr(1, 1, 0));

        // write hit and block neighbour
        write_word(block_addr(0, 0, 0), 32'h1234_5678);
        expect_hit("write hit readback", block_addr(0, 0, 0));
        expect_hit("write hit neighbour", block_addr(0, 0, 1));

        // dirty eviction in set 2
        write_word(block_addr(2, 2, 0), 32'haaaa_0001);
        write_word(block_addr(3, 2, 1), 32'hbbbb_0002);
        read_word("evict third tag", block_addr(4, 2, 0));
        read_word("dirty eviction readback", block_addr(2, 2, 0));
        read_word("dirty eviction second", block_addr(3, 2, 1));

        // LRU in set 5: A touched, so C must replace B
        write_word(block_addr(5, 5, 0), 32'hcafe_0a0a);
        write_word(block_addr(6, 5, 1), 32'hcafe_0b0b);
        expect_hit("lru touch A", block_addr(5, 5, 0));
        read_word("lru load C", block_addr(7, 5, 0));
        expect_hit("lru A kept", block_addr(5, 5, 0));
        b_addr = block_addr(6, 5, 1);
        compare_word("lru B written back", 32'hcafe_0b0b, mem_i.words[b_addr[9:2]]);

        // random traffic over 32 words
        for (int n = 0; n < 200; n++) begin
            r_addr = word_t'($urandom_range(0, 31)) << 2;
            if ($urandom_range(0, 1) == 1) begin
                write_word(r_addr, $urandom);
            end else begin
                read_word("random read", r_addr);
            end
        end

        // flush on halt, then memory must match the shadow copy
        @(negedge CLK);
        cpu  = '0;
        halt = 1'b1;
        wait_flushed();
        for (int i = 0; i < WORDS; i++) begin
            compare_word($sformatf("flush word %0d", i), shadow[i], mem_i.words[i]);
        end

        repeat (2) @(negedge CLK);
        if ((act_q.size() == 0) && (exp_q.size() == 0)) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_run("read results were left unchecked");
        end
    end

endmodule

// File: files.f
+incdir+include
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
bench/data_mem_model.sv
bench/dcache_tb.sv

// File: include/dcache_macros.svh
// Size constants for the 2-way data cache.
// Included by the package and by any RTL file that sizes its own storage.
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// 8 sets, 2 ways, 2 words per block
`define DC_SETS   8
`define DC_IDX_W  3

// byte address = tag + index + block offset + byte offset
`define DC_TAG_W  26

`define DC_WORD_W 32

`endif

// File: verilog/cache_way.sv
// One way of the data cache: line storage for all sets and the tag compare.
// The controller looks up one set and rewrites whole lines.
`include "dcache_macros.svh"

module cache_way (
    input  logic              CLK,
    input  logic              nRST,
    input  dcache_pkg::idx_t  lookup_idx,
    input  dcache_pkg::tag_t  lookup_tag,
    input  logic              wr_en,
    input  dcache_pkg::idx_t  wr_idx,
    input  dcache_pkg::line_t wr_line,
    output dcache_pkg::line_t line,
    output logic              way_hit
);
    import dcache_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    tag_t                tags [`DC_SETS];
    word_t [1:0]         words [`DC_SETS];
    logic [`DC_SETS-1:0] valid;
    logic [`DC_SETS-1:0] dirty;

    // status bits, cleared so every line starts invalid and clean
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= wr_line.valid;
            dirty[wr_idx] <= wr_line.dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tags[wr_idx]  <= wr_line.tag;
            words[wr_idx] <= wr_line.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        line.tag   = tags[lookup_idx];
        line.valid = valid[lookup_idx];
        line.dirty = dirty[lookup_idx];
        line.data  = words[lookup_idx];
    end

    // tag of an invalid line is don't care
    assign way_hit = line.valid && (line.tag == lookup_tag);

    // the controller only marks a line dirty when it also holds real data
    a_dirty_valid: assert property (
        @(posedge CLK) disable iff (!nRST)
        (wr_en && wr_line.dirty) |-> wr_line.valid
    );

endmodule

// File: verilog/dcache.sv
// Top of the 2-way write-back data cache.
// Two way stores looked up in parallel, joined by the controller.
module dcache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::cpu_req_t cpu,
    input  logic                 halt,
    output logic                 hit,
    output dcache_pkg::word_t    rdata,
    output logic                 flushed,
    output dcache_pkg::mem_req_t mem,
    input  logic                 mem_wait,
    input  dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    idx_t  lookup_idx;
    tag_t  lookup_tag;
    idx_t  wr_idx;
    line_t line0;
    line_t line1;
    line_t wr_line0;
    line_t wr_line1;
    logic  hit0;
    logic  hit1;
    logic  wr_en0;
    logic  wr_en1;

    cache_way way0_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .wr_en      (wr_en0),
        .wr_idx     (wr_idx),
        .wr_line    (wr_line0),
        .line       (line0),
        .way_hit    (hit0)
    );

    cache_way way1_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .wr_en      (wr_en1),
        .wr_idx     (wr_idx),
        .wr_line    (wr_line1),
        .line       (line1),
        .way_hit    (hit1)
    );

    dcache_ctrl ctrl_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu        (cpu),
        .halt       (halt),
        .hit        (hit),
        .rdata      (rdata),
        .flushed    (flushed),
        .line0      (line0),
        .hit0       (hit0),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .wr_en0     (wr_en0),
        .wr_line0   (wr_line0),
        .line1      (line1),
        .hit1       (hit1),
        .wr_en1     (wr_en1),
        .wr_line1   (wr_line1),
        .wr_idx     (wr_idx),
        .mem        (mem),
        .mem_wait   (mem_wait),
        .mem_rdata  (mem_rdata)
    );

endmodule

// File: verilog/dcache_ctrl.sv
// Controller of the 2-way data cache: hit path, LRU, victim write-back,
// block fill and the flush on halt, sequencing one memory request at a time.
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::cpu_req_t cpu,
    input  logic                 halt,
    output logic                 hit,
    output dcache_pkg::word_t    rdata,
    output logic                 flushed,
    input  dcache_pkg::line_t    line0,
    input  logic                 hit0,
    output dcache_pkg::idx_t     lookup_idx,
    output dcache_pkg::tag_t     lookup_tag,
    output logic                 wr_en0,
    output dcache_pkg::line_t    wr_line0,
    input  dcache_pkg::line_t    line1,
    input  logic                 hit1,
    output logic                 wr_en1,
    output dcache_pkg::line_t    wr_line1,
    output dcache_pkg::idx_t     wr_idx,
    output dcache_pkg::mem_req_t mem,
    input  logic                 mem_wait,
    input  dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    ctrl_state_e         state;
    ctrl_state_e         next_state;
    logic [`DC_SETS-1:0] lru;          // per set, the way to evict next
    idx_t                flush_idx;
    logic                flush_way;
    word_t               fill_word0;

    logic  req;
    logic  any_hit;
    line_t hit_line;
    logic  flushing;
    logic  sel_way;
    idx_t  sel_idx;
    line_t sel_line;
    logic  sel_dirty;
    logic  write_hit;
    logic  fill_done;
    logic  flush_step;
    logic  flush_last;
    line_t new_line;

    //////////////////////////////////////////////////////////////////////
    // lookup and CPU response
    //////////////////////////////////////////////////////////////////////

    assign req      = cpu.ren | cpu.wen;
    assign any_hit  = hit0 | hit1;
    assign hit_line = hit1 ? line1 : line0;

    assign hit     = (state == IDLE) && req && any_hit;
    assign rdata   = hit_line.data[cpu.addr.blkoff];
    assign flushed = (state == DONE);

    // during flush the set under lookup comes from the flush counter
    assign flushing   = (state == FLUSH0) || (state == FLUSH1);
    assign sel_idx    = flushing ? flush_idx : cpu.addr.idx;
    assign sel_way    = flushing ? flush_way : lru[cpu.addr.idx];
    assign sel_line   = sel_way ? line1 : line0;
    assign sel_dirty  = sel_line.valid && sel_line.dirty;
    assign lookup_idx = sel_idx;
    assign lookup_tag = cpu.addr.tag;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    assign flush_step = ((state == FLUSH0) && !sel_dirty) || ((state == FLUSH1) && !mem_wait);
    assign flush_last = flush_way && (flush_idx == idx_t'(`DC_SETS - 1));

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req && !any_hit) begin
                    next_state = sel_dirty ? WB0 : FILL0;   // victim needs write-back first
                end else if (halt) begin
                    next_state = FLUSH0;
                end
            end
            WB0:    if (!mem_wait) next_state = WB1;
            WB1:    if (!mem_wait) next_state = FILL0;
            FILL0:  if (!mem_wait) next_state = FILL1;
            FILL1:  if (!mem_wait) next_state = IDLE;
            FLUSH0: begin
                if (!sel_dirty) begin
                    next_state = flush_last ? DONE : FLUSH0;  // nothing to write, skip
                end else if (!mem_wait) begin
                    next_state = FLUSH1;
                end
            end
            FLUSH1: if (!mem_wait) next_state = flush_last ? DONE : FLUSH0;
            DONE:   next_state = DONE;
            default: next_state = IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // memory request
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mem = '0;
        case (state)
            WB0, FLUSH0: begin
                mem.wen   = sel_dirty;
                mem.addr  = {sel_line.tag, sel_idx, 1'b0, 2'b00};
                mem.wdata = sel_line.data[0];
            end
            WB1, FLUSH1: begin
                mem.wen   = 1'b1;
                mem.addr  = {sel_line.tag, sel_idx, 1'b1, 2'b00};
                mem.wdata = sel_line.data[1];
            end
            FILL0: begin
                mem.ren  = 1'b1;
                mem.addr = {cpu.addr.tag, cpu.addr.idx, 1'b0, 2'b00};
            end
            FILL1: begin
                mem.ren  = 1'b1;
                mem.addr = {cpu.addr.tag, cpu.addr.idx, 1'b1, 2'b00};
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // line updates
    //////////////////////////////////////////////////////////////////////

    assign write_hit = hit && cpu.wen;
    assign fill_done = (state == FILL1) && !mem_wait;

    always_comb begin
        new_line = hit_line;                          // store merge on a write hit
        new_line.data[cpu.addr.blkoff] = cpu.wdata;
        new_line.dirty = 1'b1;
        if (fill_done) begin
            new_line.tag   = cpu.addr.tag;
            new_line.valid = 1'b1;
            new_line.dirty = 1'b0;                    // filled block matches memory
            new_line.data  = {mem_rdata, fill_word0};
        end
    end

    assign wr_en0   = (write_hit && hit0) || (fill_done && !sel_way);
    assign wr_en1   = (write_hit && hit1) || (fill_done && sel_way);
    assign wr_line0 = new_line;
    assign wr_line1 = new_line;
    assign wr_idx   = cpu.addr.idx;

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            lru       <= '0;
            flush_idx <= '0;
            flush_way <= 1'b0;
        end else begin
            state <= next_state;
            if (hit) begin
                lru[cpu.addr.idx] <= hit0;            // the other way becomes the victim
            end
            if (state == IDLE) begin
                flush_idx <= '0;
                flush_way <= 1'b0;
            end else if (flush_step) begin
                flush_way <= ~flush_way;              // way 0 then way 1 of each set
                if (flush_way) begin
                    flush_idx <= flush_idx + idx_t'(1);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == FILL0) && !mem_wait) begin
            fill_word0 <= mem_rdata;
        end
    end

    a_mem_one_op: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem.ren && mem.wen)
    );

    // a stalled request stays put until memory takes it
    a_mem_hold: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((mem.ren || mem.wen) && mem_wait) |=> $stable(mem)
    );

endmodule

// File: verilog/dcache_pkg.sv
// Types shared by the data cache blocks.
// Compile first; modules reference it by scope in ports and by import inside.
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0]  tag_t;
    typedef logic [`DC_IDX_W-1:0]  idx_t;

    // split of a 32-bit byte address
    typedef struct packed {
        tag_t       tag;
        idx_t       idx;
        logic       blkoff;   // word within the block
        logic [1:0] bytoff;
    } dcache_addr_t;

    typedef struct packed {
        logic         ren;
        logic         wen;
        dcache_addr_t addr;
        word_t        wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;          // word aligned, byte offset zero
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        tag_t        tag;
        logic        valid;
        logic        dirty;
        word_t [1:0] data;    // data[1] is the upper word of the block
    } line_t;

    typedef enum logic [2:0] {
        IDLE, WB0, WB1, FILL0, FILL1, FLUSH0, FLUSH1, DONE
    } ctrl_state_e;

endpackage
